// ==== rtl/flash_pkg.sv ====
// ==========================================================================
// Shared types and register layout for the single-SPI XIP flash controller
// Only io0 and io1 exist, and config lane 2 has no fields
// ==========================================================================
package flash_pkg;

    typedef logic [31:0] word_t;
    typedef logic [23:0] flash_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  byte_tag_t;   // 0 for cmd/addr, 1..4 for data bytes

    typedef enum logic [7:0] {
        CMD_RESET_EN = 8'h66,
        CMD_RESET    = 8'h99,
        CMD_READ     = 8'h03
    } flash_cmd_e;

    typedef enum logic [3:0] {
        ST_RESET_EN, ST_RESET_EN_WAIT, ST_RESET, ST_RESET_WAIT,
        ST_READ_CMD, ST_ADDR_HI, ST_ADDR_MID, ST_ADDR_LO,
        ST_DATA_0, ST_DATA_1, ST_DATA_2, ST_DATA_3
    } ctrl_state_e;

    localparam int CFG_EN_BIT  = 31;
    localparam int CFG_OE_LSB  = 8;
    localparam int CFG_OE_W    = 2;
    localparam int CFG_CSB_BIT = 5;
    localparam int CFG_CLK_BIT = 4;
    localparam int CFG_DO_LSB  = 0;
    localparam int CFG_DO_W    = 2;

    localparam int CFG_LANE_PINS = 0;
    localparam int CFG_LANE_OE   = 1;
    localparam int CFG_LANE_EN   = 3;

    localparam int unsigned WORD_BYTES = 4;   // Byte step between sequential words

endpackage

// ==== rtl/spi_byte_xfer.sv ====
// ==========================================================================
// One-byte SPI mode 0 shifter, MSB first, 16 system clocks per byte
// CS stays low between bytes, only a reset ends the transaction
// ==========================================================================
`timescale 1ns/100ps

module spi_byte_xfer import flash_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      byte_valid,
    output logic      byte_ready,
    input  byte_t     byte_data,
    input  byte_tag_t byte_tag,
    output logic      rx_valid,
    output byte_t     rx_data,
    output byte_tag_t rx_tag,
    output logic      flash_csb,
    output logic      flash_clk,
    output logic      flash_io0_do,
    input  logic      flash_io1_di
);
    byte_t      obuf;
    byte_t      ibuf;
    byte_tag_t  xfer_tag;
    logic [3:0] bit_cnt;
    logic       idle;
    logic       last_fall;

    assign idle       = (bit_cnt == 4'd0);
    assign last_fall  = (bit_cnt == 4'd1) && flash_clk;  // Eighth falling edge next
    assign byte_ready = byte_valid && idle;

    assign flash_io0_do = obuf[7];
    assign rx_data      = ibuf;
    assign rx_tag       = xfer_tag;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            flash_csb <= 1'b1;
            flash_clk <= 1'b0;
            bit_cnt   <= 4'd0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= last_fall;
            if (byte_valid && byte_ready) begin
                flash_csb <= 1'b0;
                flash_clk <= 1'b0;
                bit_cnt   <= 4'd8;
            end else if (!idle) begin
                flash_clk <= !flash_clk && !flash_csb;
                if (flash_clk)
                    bit_cnt <= bit_cnt - 4'd1;  // One bit per falling edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && byte_ready) begin
            obuf     <= byte_data;
            xfer_tag <= byte_tag;
        end else if (!idle) begin
            if (flash_clk)
                obuf <= {obuf[6:0], 1'b0};          // Shift out on falling edge
            else
                ibuf <= {ibuf[6:0], flash_io1_di};  // Sample on rising edge
        end
    end

endmodule

// ==== rtl/flash_mode_regs.sv ====
// ==========================================================================
// Config register, soft reset and pin mux between bit-bang and controller
// Any lane write or a clear enable bit holds the controller in reset
// ==========================================================================
`timescale 1ns/100ps

module flash_mode_regs import flash_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic [3:0] cfgreg_we,
    input  word_t      cfgreg_di,
    output word_t      cfgreg_do,
    output logic       ctrl_resetn,
    input  logic       xfer_csb,
    input  logic       xfer_clk,
    input  logic       xfer_io0_do,
    output logic       flash_csb,
    output logic       flash_clk,
    output logic       flash_io0_oe,
    output logic       flash_io1_oe,
    output logic       flash_io0_do,
    output logic       flash_io1_do,
    input  logic       flash_io0_di,
    input  logic       flash_io1_di
);
    logic                config_en;
    logic                config_csb;
    logic                config_clk;
    logic [CFG_OE_W-1:0] config_oe;
    logic [CFG_DO_W-1:0] config_do;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ctrl_resetn <= 1'b0;
            config_en   <= 1'b1;       // Controller owns the pins after reset
            config_csb  <= 1'b0;
            config_clk  <= 1'b0;
            config_oe   <= '0;
            config_do   <= '0;
        end else begin
            ctrl_resetn <= config_en && !(|cfgreg_we);
            if (cfgreg_we[CFG_LANE_PINS]) begin
                config_csb <= cfgreg_di[CFG_CSB_BIT];
                config_clk <= cfgreg_di[CFG_CLK_BIT];
                config_do  <= cfgreg_di[CFG_DO_LSB +: CFG_DO_W];
            end
            if (cfgreg_we[CFG_LANE_OE])
                config_oe <= cfgreg_di[CFG_OE_LSB +: CFG_OE_W];
            if (cfgreg_we[CFG_LANE_EN])
                config_en <= cfgreg_di[CFG_EN_BIT];
        end
    end

    // In SPI mode io0 is MOSI and io1 is MISO, io0 released during soft reset
    assign flash_csb    = config_en ? xfer_csb    : config_csb;
    assign flash_clk    = config_en ? xfer_clk    : config_clk;
    assign flash_io0_oe = config_en ? ctrl_resetn : config_oe[0];
    assign flash_io1_oe = config_en ? 1'b0        : config_oe[1];
    assign flash_io0_do = config_en ? xfer_io0_do : config_do[0];
    assign flash_io1_do = config_en ? 1'b0        : config_do[1];

    always_comb begin
        cfgreg_do = '0;
        cfgreg_do[CFG_EN_BIT]  = config_en;
        cfgreg_do[CFG_OE_LSB +: CFG_OE_W] = {flash_io1_oe, flash_io0_oe};
        cfgreg_do[CFG_CSB_BIT] = flash_csb;      // Live pin levels
        cfgreg_do[CFG_CLK_BIT] = flash_clk;
        cfgreg_do[CFG_DO_LSB +: CFG_DO_W] = {flash_io1_di, flash_io0_di};
    end

endmodule

// ==== rtl/flash_read_ctrl.sv ====
// ==========================================================================
// Command FSM: flash reset sequence, 0x03 read, sequential word prefetch
// Assumes the host keeps addr steady from valid until ready
// A non-sequential request aborts the burst and sends a new command
// ==========================================================================
`timescale 1ns/100ps

module flash_read_ctrl import flash_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        ctrl_resetn,
    input  logic        valid,
    input  flash_addr_t addr,
    output logic        ready,
    output word_t       rdata,
    output logic        byte_valid,
    input  logic        byte_ready,
    output byte_t       byte_data,
    output byte_tag_t   byte_tag,
    output logic        xfer_resetn,
    input  logic        rx_valid,
    input  byte_t       rx_data,
    input  byte_tag_t   rx_tag
);
    ctrl_state_e state;
    flash_addr_t rd_addr;
    flash_addr_t next_addr;
    logic [23:0] buffer;
    logic        rd_valid;
    logic        rd_wait;
    logic        rd_inc;
    logic        jump;

    assign next_addr = rd_addr + flash_addr_t'(WORD_BYTES);
    assign ready = valid && (addr == rd_addr) && rd_valid;
    // Neither the held word nor the one being fetched
    assign jump  = valid && !ready && (addr != next_addr) && rd_valid;

    // Word assembly, little-endian by slot
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (rx_tag)
                3'd1: buffer[7:0]   <= rx_data;
                3'd2: buffer[15:8]  <= rx_data;
                3'd3: buffer[23:16] <= rx_data;
                3'd4: begin
                    rdata   <= {rx_data, buffer};
                    rd_addr <= rd_inc ? next_addr : addr;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || !ctrl_resetn) begin
            state       <= ST_RESET_EN;
            xfer_resetn <= 1'b0;
            byte_valid  <= 1'b0;
            rd_valid    <= 1'b0;
            rd_wait     <= 1'b0;
            rd_inc      <= 1'b0;
        end else begin
            xfer_resetn <= 1'b1;
            byte_valid  <= 1'b0;

            if (rx_valid && rx_tag == 3'd4) begin
                rd_valid <= 1'b1;
                rd_wait  <= rd_inc;           // Prefetched word waits for the host
                rd_inc   <= 1'b1;
            end
            if (valid)
                rd_wait <= 1'b0;

            case (state)
                ST_RESET_EN, ST_RESET, ST_READ_CMD: begin
                    byte_valid <= !byte_ready;
                    byte_tag   <= 3'd0;
                    case (state)
                        ST_RESET_EN: byte_data <= CMD_RESET_EN;
                        ST_RESET:    byte_data <= CMD_RESET;
                        default:     byte_data <= CMD_READ;
                    endcase
                    if (state == ST_READ_CMD)
                        rd_inc <= 1'b0;
                    if (byte_ready)
                        state <= ctrl_state_e'(state + 4'd1);
                end
                ST_RESET_EN_WAIT, ST_RESET_WAIT: begin
                    if (rx_valid) begin
                        xfer_resetn <= 1'b0;  // Each reset command is its own transaction
                        state <= ctrl_state_e'(state + 4'd1);
                    end
                end
                ST_ADDR_HI: begin
                    if (valid && !ready) begin
                        byte_valid <= !byte_ready;
                        byte_tag   <= 3'd0;
                        byte_data  <= addr[23:16];
                        if (byte_ready)
                            state <= ST_ADDR_MID;
                    end
                end
                ST_ADDR_MID: begin
                    byte_valid <= !byte_ready;
                    byte_tag   <= 3'd0;
                    byte_data  <= addr[15:8];
                    if (byte_ready)
                        state <= ST_ADDR_LO;
                end
                ST_ADDR_LO: begin
                    byte_valid <= !byte_ready;
                    byte_tag   <= 3'd0;
                    byte_data  <= addr[7:0];
                    if (byte_ready) begin
                        byte_data <= 8'h00;   // Dummy MOSI during data phase
                        state     <= ST_DATA_0;
                    end
                end
                ST_DATA_0, ST_DATA_1, ST_DATA_2: begin
                    byte_valid <= !byte_ready;
                    byte_tag   <= byte_tag_t'(state - ST_DATA_0 + 4'd1);
                    if (byte_ready)
                        state <= ctrl_state_e'(state + 4'd1);
                end
                ST_DATA_3: begin
                    if (!rd_wait || valid) begin
                        byte_valid <= !byte_ready;
                        byte_tag   <= 3'd4;
                        if (byte_ready)
                            state <= ST_DATA_0;
                    end
                end
                default: state <= ST_RESET_EN;
            endcase

            if (jump) begin
                rd_inc      <= 1'b0;
                rd_valid    <= 1'b0;
                byte_valid  <= 1'b0;
                xfer_resetn <= 1'b0;          // Raise CS, then new command and address
                state       <= ST_READ_CMD;
            end
        end
    end

endmodule

// ==== rtl/spi_flash_top.sv ====
// ==========================================================================
// Read-only single-SPI flash controller for execute-in-place fetches
// Host holds valid and addr until ready, rdata is valid while ready is high
// ==========================================================================
`timescale 1ns/100ps

module spi_flash_top import flash_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  flash_addr_t addr,
    output logic        ready,
    output word_t       rdata,
    output logic        flash_csb,
    output logic        flash_clk,
    output logic        flash_io0_oe,
    output logic        flash_io1_oe,
    output logic        flash_io0_do,
    output logic        flash_io1_do,
    input  logic        flash_io0_di,
    input  logic        flash_io1_di,
    input  logic [3:0]  cfgreg_we,
    input  word_t       cfgreg_di,
    output word_t       cfgreg_do
);
    logic      ctrl_resetn;
    logic      xfer_resetn;
    logic      xfer_rstn;
    logic      byte_valid;
    logic      byte_ready;
    byte_t     byte_data;
    byte_tag_t byte_tag;
    logic      rx_valid;
    byte_t     rx_data;
    byte_tag_t rx_tag;
    logic      xfer_csb;
    logic      xfer_clk;
    logic      xfer_io0_do;

    // Shifter restarts on hard reset, soft reset or end of transaction
    assign xfer_rstn = resetn && ctrl_resetn && xfer_resetn;

    flash_mode_regs u_regs (
        .clk(clk), .resetn(resetn),
        .cfgreg_we(cfgreg_we), .cfgreg_di(cfgreg_di), .cfgreg_do(cfgreg_do),
        .ctrl_resetn(ctrl_resetn),
        .xfer_csb(xfer_csb), .xfer_clk(xfer_clk), .xfer_io0_do(xfer_io0_do),
        .flash_csb(flash_csb), .flash_clk(flash_clk),
        .flash_io0_oe(flash_io0_oe), .flash_io1_oe(flash_io1_oe),
        .flash_io0_do(flash_io0_do), .flash_io1_do(flash_io1_do),
        .flash_io0_di(flash_io0_di), .flash_io1_di(flash_io1_di)
    );

    flash_read_ctrl u_ctrl (
        .clk(clk), .resetn(resetn), .ctrl_resetn(ctrl_resetn),
        .valid(valid), .addr(addr), .ready(ready), .rdata(rdata),
        .byte_valid(byte_valid), .byte_ready(byte_ready),
        .byte_data(byte_data), .byte_tag(byte_tag), .xfer_resetn(xfer_resetn),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_tag(rx_tag)
    );

    spi_byte_xfer u_xfer (
        .clk(clk), .resetn(xfer_rstn),
        .byte_valid(byte_valid), .byte_ready(byte_ready),
        .byte_data(byte_data), .byte_tag(byte_tag),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_tag(rx_tag),
        .flash_csb(xfer_csb), .flash_clk(xfer_clk),
        .flash_io0_do(xfer_io0_do), .flash_io1_di(flash_io1_di)
    );

endmodule

// ==== verif/spi_flash_model.sv ====
// ==========================================================================
// Behavioral single-SPI flash, mode 0, reset and 0x03 read only
// Byte at address b is b[23:16] ^ b[15:8] ^ b[7:0] ^ 0xA5
// Low io0_oe means the host dropped the bus, so a new reset pair is needed
// ==========================================================================
`timescale 1ns/100ps

module spi_flash_model import flash_pkg::*; (
    input  logic csb,
    input  logic sclk,
    input  logic io0_oe,
    input  logic mosi,
    output logic miso,
    output logic protocol_err
);
    byte_t       shreg;
    byte_t       cmd;
    byte_t       dbyte;
    flash_addr_t rd_addr;
    int          nbits;
    int          k;
    logic        sclk_q;
    logic        rst_en;
    logic        rst_done;

    function automatic byte_t mem_byte(flash_addr_t b);
        return b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'hA5;
    endfunction

    initial begin
        miso         = 1'b0;
        protocol_err = 1'b0;
        nbits        = 0;
        cmd          = 8'h00;
        rst_en       = 1'b0;
        rst_done     = 1'b0;
        sclk_q       = 1'b0;
    end

    always @(sclk or csb or io0_oe) begin
        if (io0_oe !== 1'b1) begin
            nbits    = 0;                      // Flash state lost
            cmd      = 8'h00;
            rst_en   = 1'b0;
            rst_done = 1'b0;
            miso     = 1'b0;
        end else if (csb !== 1'b0) begin
            nbits = 0;
            cmd   = 8'h00;
            miso  = 1'b0;
        end else if (sclk === 1'b1 && sclk_q === 1'b0) begin
            shreg = {shreg[6:0], mosi};        // Sample on rising edge
            nbits = nbits + 1;
            if (nbits == 8) begin
                cmd = shreg;
                case (shreg)
                    8'h66: rst_en = 1'b1;
                    8'h99: begin
                        rst_done = rst_en;
                        rst_en   = 1'b0;
                    end
                    8'h03: if (!rst_done) protocol_err = 1'b1;
                    default: protocol_err = 1'b1;
                endcase
            end else if (cmd == 8'h03 && (nbits == 16 || nbits == 24 || nbits == 32)) begin
                rd_addr = {rd_addr[15:0], shreg};
            end
        end else if (sclk === 1'b0 && sclk_q === 1'b1) begin
            if (cmd == 8'h03 && nbits >= 32) begin
                k     = nbits - 32;            // Data bit index, MSB first per byte
                dbyte = mem_byte(rd_addr + flash_addr_t'(k / 8));
                miso  = dbyte[7 - (k % 8)];
            end
        end
        sclk_q = sclk;
    end

endmodule

// ==== verif/spi_flash_top_assert.sv ====
// ==========================================================================
// Concurrent checks on the flash pins and the host handshake
// Sampled on the rising system clock edge
// ==========================================================================
`timescale 1ns/100ps

module spi_flash_top_assert import flash_pkg::*; (
    input logic  clk,
    input logic  resetn,
    input logic  valid,
    input logic  ready,
    input word_t rdata,
    input logic  flash_csb,
    input logic  flash_clk,
    input word_t cfgreg_do
);
    // Serial clock idles low outside a transaction
    clk_low_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        (flash_csb && cfgreg_do[CFG_EN_BIT]) |-> !flash_clk)
        else $error("flash_clk high while chip select is high");

    // Returned word answers a live request and is fully known
    ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        ready |-> (valid && !$isunknown(rdata)))
        else $error("ready without valid or with unknown rdata");

    csb_high_after_reset: assert property (@(posedge clk)
        !resetn |=> flash_csb)
        else $error("chip select low right after reset");

endmodule

bind spi_flash_top spi_flash_top_assert u_assert (
    .clk(clk), .resetn(resetn), .valid(valid), .ready(ready), .rdata(rdata),
    .flash_csb(flash_csb), .flash_clk(flash_clk), .cfgreg_do(cfgreg_do)
);

// ==== verif/tb_spi_flash_top.sv ====
// ==========================================================================
// Testbench for the SPI flash controller, table driven
// io0 is looped back to its input, io1 comes from the flash model
// ==========================================================================
`timescale 1ns/100ps

module tb_spi_flash_top import flash_pkg::*; ();
    typedef enum logic {E_READ, E_CFG} entry_kind_e;
    typedef struct {
        entry_kind_e kind;
        flash_addr_t addr;
        int          lane;
        word_t       data;
        word_t       exp;
        word_t       mask;
        logic        pins;     // Compare flash pins against exp fields
        logic        io1_do;   // Bit-bang io1 output, not visible in cfgreg_do
    } entry_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    flash_addr_t addr;
    logic        ready;
    word_t       rdata;
    logic        flash_csb, flash_clk, flash_io0_oe, flash_io1_oe;
    logic        flash_io0_do, flash_io1_do, flash_io1_di;
    logic [3:0]  cfgreg_we;
    word_t       cfgreg_di;
    word_t       cfgreg_do;
    logic        protocol_err;
    entry_t      tbl[$];

    spi_flash_top u_dut (
        .clk(clk), .resetn(resetn), .valid(valid), .addr(addr), .ready(ready),
        .rdata(rdata), .flash_csb(flash_csb), .flash_clk(flash_clk),
        .flash_io0_oe(flash_io0_oe), .flash_io1_oe(flash_io1_oe),
        .flash_io0_do(flash_io0_do), .flash_io1_do(flash_io1_do),
        .flash_io0_di(flash_io0_do), .flash_io1_di(flash_io1_di),
        .cfgreg_we(cfgreg_we), .cfgreg_di(cfgreg_di), .cfgreg_do(cfgreg_do)
    );

    spi_flash_model u_flash (
        .csb(flash_csb), .sclk(flash_clk), .io0_oe(flash_io0_oe),
        .mosi(flash_io0_do), .miso(flash_io1_di), .protocol_err(protocol_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic byte_t rule_byte(flash_addr_t b);
        return b[23:16] ^ b[15:8] ^ b[7:0] ^ 8'hA5;
    endfunction

    function automatic word_t rule_word(flash_addr_t a);
        return {rule_byte(a + 24'd3), rule_byte(a + 24'd2), rule_byte(a + 24'd1), rule_byte(a)};
    endfunction

    function automatic void push_read(flash_addr_t a);
        tbl.push_back('{E_READ, a, 0, '0, rule_word(a), 32'hFFFF_FFFF, 1'b0, 1'b0});
    endfunction

    function automatic void push_cfg(int lane, word_t d, word_t e, word_t m, logic p, logic o);
        tbl.push_back('{E_CFG, '0, lane, d, e, m, p, o});
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_pin(string name, logic got, logic exp);
        if (got !== exp)
            report_failure($sformatf("FAILED at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic do_read(entry_t e);
        int   cycles;
        logic seen;
        valid  = 1'b1;
        addr   = e.addr;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 4000) begin
            @(negedge clk);
            cycles++;
            if (ready === 1'b1)
                seen = 1'b1;
        end
        if (!seen)
            report_failure($sformatf("No ready within 4000 cycles for address %h", e.addr));
        check_word("rdata", rdata, e.exp);
        @(negedge clk);                        // Handshake completes on this edge
        valid = 1'b0;
    endtask

    task automatic do_cfg(entry_t e);
        cfgreg_we = 4'b0001 << e.lane;
        cfgreg_di = e.data;
        @(negedge clk);
        cfgreg_we = 4'b0000;
        @(negedge clk);
        check_word("cfgreg_do", cfgreg_do & e.mask, e.exp);
        if (e.pins) begin
            check_pin("flash_csb", flash_csb, e.exp[CFG_CSB_BIT]);
            check_pin("flash_clk", flash_clk, e.exp[CFG_CLK_BIT]);
            check_pin("flash_io0_oe", flash_io0_oe, e.exp[CFG_OE_LSB]);
            check_pin("flash_io1_oe", flash_io1_oe, e.exp[CFG_OE_LSB + 1]);
            check_pin("flash_io0_do", flash_io0_do, e.exp[CFG_DO_LSB]);
            check_pin("flash_io1_do", flash_io1_do, e.io1_do);
        end
    endtask

    always @(posedge clk) begin
        if (protocol_err === 1'b1)
            report_failure("Flash model saw a command out of order or an unknown opcode");
    end

    initial begin
        flash_addr_t ra;
        flash_addr_t last;
        void'($urandom(32'h38b5_4af1));
        valid     = 1'b0;
        addr      = '0;
        cfgreg_we = 4'b0000;
        cfgreg_di = '0;
        resetn    = 1'b0;

        push_read(24'h000100);
        push_read(24'h002040);                 // Sequential burst
        push_read(24'h002044);
        push_read(24'h002048);
        last = 24'h002048;
        for (int i = 0; i < 4; i++) begin
            ra = flash_addr_t'($urandom()) & 24'hFF_FFFC;
            if (ra == last + 24'd4)
                ra = ra + 24'd8;
            push_read(ra);
            last = ra;
        end
        push_cfg(CFG_LANE_EN, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF, 1'b1, 1'b0);
        push_cfg(CFG_LANE_PINS, 32'h0000_0033, 32'h0000_0031, 32'hFFFF_FFFF, 1'b1, 1'b1);
        push_cfg(CFG_LANE_OE, 32'h0000_0300, 32'h0000_0331, 32'hFFFF_FFFF, 1'b1, 1'b1);
        push_cfg(CFG_LANE_EN, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0);
        push_read(24'h00A5C0);
        push_cfg(2, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FC00, 1'b0, 1'b0);
        push_read(24'h000104);

        repeat (4) @(negedge clk);
        resetn = 1'b1;

        foreach (tbl[i]) begin
            if (tbl[i].kind == E_READ)
                do_read(tbl[i]);
            else
                do_cfg(tbl[i]);
        end
        check_pin("protocol_err", protocol_err, 1'b0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/flash_pkg.sv
rtl/spi_byte_xfer.sv
rtl/flash_mode_regs.sv
rtl/flash_read_ctrl.sv
rtl/spi_flash_top.sv
verif/spi_flash_model.sv
verif/spi_flash_top_assert.sv
verif/tb_spi_flash_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_spi_flash_top -Mdir obj_dir -f src.f
	./obj_dir/Vtb_spi_flash_top | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
